// ==== alu_consts.svh ====
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// Data word width of the execute unit
`define ALU_XLEN 32

// Low bits of operand B used as shift amount or bit index
`define ALU_SHAMT_W 5

// Cycles from multiplier input strobe to product
`define ALU_MUL_STAGES 4

// One quotient bit per iteration
`define ALU_DIV_ITERS 32

`endif

// ==== alu_pkg.sv ====
`default_nettype none

`include "alu_consts.svh"

package alu_pkg;

  typedef logic [`ALU_XLEN-1:0]   word_t;      // Operand or result
  typedef logic [2*`ALU_XLEN-1:0] dword_t;     // Full product
  typedef logic [`ALU_XLEN:0]     mul_opnd_t;  // Sign- or zero-extended multiplier input
  typedef logic [`ALU_SHAMT_W-1:0] shamt_t;    // Shift amount or bit index

  // Operation select, no instruction fields behind it
  typedef enum logic [5:0] {
    ADD, SUB, AND, OR, XOR,
    SLL, SRL, SRA,
    SLT, SLTU,
    SH1ADD, SH2ADD, SH3ADD,            // Shift-and-add
    BSET, BCLR, BINV, BEXT,            // Single-bit ops
    ANDN, ORN, XNOR,
    MIN, MINU, MAX, MAXU,
    ROL, ROR,
    SEXT_B, SEXT_H,
    MUL, MULH, MULHSU, MULHU,          // Pipelined multiplier
    DIV, DIVU, REM, REMU               // Iterative divider
  } alu_op_e;

  // Request as it arrives with the strobe
  typedef struct packed {
    alu_op_e op;
    word_t   a;
    word_t   b;
  } alu_req_t;

  typedef struct packed {
    word_t result;
  } alu_rsp_t;

  // Special-case results for divide
  localparam word_t SIGNED_MIN   = {1'b1, {(`ALU_XLEN-1){1'b0}}};
  localparam word_t NEG_ONE      = '1;
  localparam word_t UNSIGNED_MAX = '1;  // Same bits as NEG_ONE, unsigned meaning

endpackage

`default_nettype wire

// ==== alu_int_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_int_unit (
  input  alu_pkg::alu_op_e i_op,
  input  alu_pkg::word_t   i_a,
  input  alu_pkg::word_t   i_b,
  output alu_pkg::word_t   o_result
);

  import alu_pkg::*;

  logic [32:0] diff;      // Shared 33-bit subtract, sign in bit 32
  logic        lt_s;
  logic        lt_u;
  shamt_t      shamt;
  word_t       shr;       // Logical right shift, reused by BEXT
  word_t       bit_mask;  // One-hot at the bit index
  dword_t      ror_wide;
  dword_t      rol_wide;

  assign shamt = shamt_t'(i_b);  // Only low five bits matter
  assign diff  = {i_a[31], i_a} - {i_b[31], i_b};

  // Signed less-than straight from the widened difference
  assign lt_s = diff[32];
  // Unsigned: differing top bits decide on their own
  assign lt_u = (i_a[31] ^ i_b[31]) ? i_b[31] : diff[32];

  assign shr      = i_a >> shamt;
  assign bit_mask = word_t'(1) << shamt;

  // Funnel shift of {a,a} gives both rotates without an OR of two shifts
  assign ror_wide = {i_a, i_a} >> shamt;
  assign rol_wide = {i_a, i_a} << shamt;

  always_comb begin
    o_result = '0;  // Multiply and divide codes land here
    unique case (i_op)
      ADD:    o_result = i_a + i_b;
      SUB:    o_result = diff[31:0];
      AND:    o_result = i_a & i_b;
      OR:     o_result = i_a | i_b;
      XOR:    o_result = i_a ^ i_b;
      SLL:    o_result = i_a << shamt;
      SRL:    o_result = shr;
      SRA:    o_result = $signed(i_a) >>> shamt;  // Fill with sign
      SLT:    o_result = word_t'(lt_s);
      SLTU:   o_result = word_t'(lt_u);

      // Address generation
      SH1ADD: o_result = (i_a << 1) + i_b;
      SH2ADD: o_result = (i_a << 2) + i_b;
      SH3ADD: o_result = (i_a << 3) + i_b;

      BSET:   o_result = i_a | bit_mask;
      BCLR:   o_result = i_a & ~bit_mask;
      BINV:   o_result = i_a ^ bit_mask;
      BEXT:   o_result = word_t'(shr[0]);

      ANDN:   o_result = i_a & ~i_b;
      ORN:    o_result = i_a | ~i_b;
      XNOR:   o_result = ~(i_a ^ i_b);

      // Min and max reuse the compare results
      MIN:    o_result = lt_s ? i_a : i_b;
      MINU:   o_result = lt_u ? i_a : i_b;
      MAX:    o_result = lt_s ? i_b : i_a;
      MAXU:   o_result = lt_u ? i_b : i_a;

      ROL:    o_result = rol_wide[63:32];  // Upper half after left funnel
      ROR:    o_result = ror_wide[31:0];

      SEXT_B: o_result = {{24{i_a[7]}}, i_a[7:0]};
      SEXT_H: o_result = {{16{i_a[15]}}, i_a[15:0]};
      default: o_result = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== alu_multiplier.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_multiplier (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_valid,
  input  alu_pkg::mul_opnd_t i_a,
  input  alu_pkg::mul_opnd_t i_b,
  output logic               o_valid,
  output alu_pkg::dword_t    o_product
);

  import alu_pkg::*;

  // Operands split as signed 17-bit high part and unsigned 16-bit low part
  mul_opnd_t          a_q;
  mul_opnd_t          b_q;
  logic [31:0]        pp_ll_q;
  logic signed [33:0] pp_hl_q;
  logic signed [33:0] pp_lh_q;
  logic signed [33:0] pp_hh_q;
  dword_t             t_ll_q;  // Partial products aligned to their weight
  dword_t             t_hl_q;
  dword_t             t_lh_q;
  dword_t             t_hh_q;
  logic [3:0]         vld_q;   // One valid bit per stage

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      vld_q <= '0;
    end else begin
      vld_q <= {vld_q[2:0], i_valid};
    end
  end

  assign o_valid = vld_q[3];

  always_ff @(posedge i_clk) begin
    // Stage 1 captures operands
    a_q <= i_a;
    b_q <= i_b;

    // Stage 2, four small multiplies
    pp_ll_q <= a_q[15:0] * b_q[15:0];
    pp_hl_q <= $signed(a_q[32:16]) * $signed({1'b0, b_q[15:0]});
    pp_lh_q <= $signed({1'b0, a_q[15:0]}) * $signed(b_q[32:16]);
    pp_hh_q <= $signed(a_q[32:16]) * $signed(b_q[32:16]);

    // Stage 3, sign-extend and shift into 64-bit position
    t_ll_q <= {32'd0, pp_ll_q};
    t_hl_q <= {{14{pp_hl_q[33]}}, pp_hl_q, 16'd0};
    t_lh_q <= {{14{pp_lh_q[33]}}, pp_lh_q, 16'd0};
    t_hh_q <= {pp_hh_q[31:0], 32'd0};  // Bits above 63 drop out

    // Stage 4 final sum
    o_product <= t_ll_q + t_hl_q + t_lh_q + t_hh_q;
  end

endmodule

`default_nettype wire

// ==== alu_divider.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module alu_divider (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_start,
  input  logic           i_signed,
  input  alu_pkg::word_t i_dividend,
  input  alu_pkg::word_t i_divisor,
  output logic           o_done,
  output alu_pkg::word_t o_quotient,
  output alu_pkg::word_t o_remainder
);

  import alu_pkg::*;

  typedef enum logic {IDLE, RUN} div_state_e;

  div_state_e                        state_q;
  logic [$clog2(`ALU_DIV_ITERS)-1:0] iter_q;
  logic                              last_iter;
  word_t                             quo_q;      // Dividend shifts out, quotient shifts in
  word_t                             rem_q;      // Partial remainder
  word_t                             dvsr_q;     // Divisor magnitude
  logic                              neg_quo_q;
  logic                              neg_rem_q;  // Remainder takes the dividend sign
  word_t                             mag_dividend;
  word_t                             mag_divisor;
  logic [32:0]                       shifted;
  logic [33:0]                       trial;
  word_t                             quo_next;
  word_t                             rem_next;

  assign mag_dividend = (i_signed && i_dividend[31]) ? -i_dividend : i_dividend;
  assign mag_divisor  = (i_signed && i_divisor[31]) ? -i_divisor : i_divisor;

  assign last_iter = (iter_q == $bits(iter_q)'(`ALU_DIV_ITERS - 1));

  // One restoring step, bring in the next dividend bit and try to subtract
  always_comb begin
    shifted = {rem_q, quo_q[31]};
    trial   = {1'b0, shifted} - {2'b00, dvsr_q};
    if (trial[33]) begin
      rem_next = shifted[31:0];  // Restore
      quo_next = {quo_q[30:0], 1'b0};
    end else begin
      rem_next = trial[31:0];
      quo_next = {quo_q[30:0], 1'b1};
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state_q <= IDLE;
      iter_q  <= '0;
      o_done  <= 1'b0;
    end else begin
      o_done <= 1'b0;
      unique case (state_q)
        IDLE: if (i_start) begin
          state_q <= RUN;
          iter_q  <= '0;
        end
        RUN: begin
          iter_q <= iter_q + 1'b1;
          if (last_iter) begin
            state_q <= IDLE;
            o_done  <= 1'b1;  // Results already sign-corrected
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (state_q == IDLE && i_start) begin
      quo_q     <= mag_dividend;
      rem_q     <= '0;
      dvsr_q    <= mag_divisor;
      neg_quo_q <= i_signed && (i_dividend[31] ^ i_divisor[31]);
      neg_rem_q <= i_signed && i_dividend[31];
    end else if (state_q == RUN) begin
      if (last_iter) begin
        // Final step writes signed results in place
        quo_q <= neg_quo_q ? -quo_next : quo_next;
        rem_q <= neg_rem_q ? -rem_next : rem_next;
      end else begin
        quo_q <= quo_next;
        rem_q <= rem_next;
      end
    end
  end

  assign o_quotient  = quo_q;
  assign o_remainder = rem_q;

endmodule

`default_nettype wire

// ==== alu_muldiv_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "alu_consts.svh"

module alu_muldiv_seq (
  input  logic               i_clk,
  input  logic               i_rst,
  input  logic               i_req_valid,
  input  alu_pkg::alu_req_t  i_req,
  input  alu_pkg::word_t     i_int_result,
  input  alu_pkg::dword_t    i_product,
  input  logic               i_mul_valid,
  input  logic               i_div_done,
  input  alu_pkg::word_t     i_quotient,
  input  alu_pkg::word_t     i_remainder,
  output logic               o_mul_valid,
  output alu_pkg::mul_opnd_t o_mul_a,
  output alu_pkg::mul_opnd_t o_mul_b,
  output logic               o_div_start,
  output logic               o_div_signed,
  output alu_pkg::word_t     o_dividend,
  output alu_pkg::word_t     o_divisor,
  output logic               o_rsp_valid,
  output alu_pkg::alu_rsp_t  o_rsp,
  output logic               o_busy
);

  import alu_pkg::*;

  logic                                    is_mul;
  logic                                    is_div;
  logic                                    accept;
  logic                                    sext_a;  // Operand extension for the multiplier
  logic                                    sext_b;
  logic [$clog2(`ALU_MUL_STAGES + 1)-1:0] mul_cnt_q;  // Multiplies in flight
  logic [`ALU_MUL_STAGES-1:0]              hi_pipe_q;  // High-half select, tracks product
  logic                                    div_busy_q;
  alu_op_e                                 div_op_q;
  word_t                                   div_a_q;
  word_t                                   div_b_q;
  logic                                    int_valid_q;
  word_t                                   int_result_q;
  logic                                    div_is_rem;
  logic                                    div_by_zero;
  logic                                    div_ovf;
  word_t                                   div_result;
  word_t                                   mul_result;

  assign is_mul = i_req.op inside {MUL, MULH, MULHSU, MULHU};
  assign is_div = i_req.op inside {DIV, DIVU, REM, REMU};

  // Multiplies may stream behind each other, everything else waits for idle
  assign accept = i_req_valid && (!o_busy || (is_mul && !div_busy_q));

  assign sext_a  = i_req.op inside {MULH, MULHSU};
  assign sext_b  = (i_req.op == MULH);
  assign o_mul_a = {sext_a & i_req.a[31], i_req.a};
  assign o_mul_b = {sext_b & i_req.b[31], i_req.b};
  assign o_mul_valid = accept && is_mul;

  assign o_div_start  = accept && is_div;
  assign o_div_signed = i_req.op inside {DIV, REM};
  assign o_dividend   = i_req.a;
  assign o_divisor    = i_req.b;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      mul_cnt_q   <= '0;
      div_busy_q  <= 1'b0;
      int_valid_q <= 1'b0;
    end else begin
      unique case ({o_mul_valid, i_mul_valid})
        2'b10:   mul_cnt_q <= mul_cnt_q + 1'b1;
        2'b01:   mul_cnt_q <= mul_cnt_q - 1'b1;
        default: mul_cnt_q <= mul_cnt_q;  // Issue and retire cancel out
      endcase
      if (o_div_start) begin
        div_busy_q <= 1'b1;
      end else if (i_div_done) begin
        div_busy_q <= 1'b0;
      end
      int_valid_q <= accept && !is_mul && !is_div;
    end
  end

  always_ff @(posedge i_clk) begin
    hi_pipe_q <= {hi_pipe_q[`ALU_MUL_STAGES-2:0], i_req.op != MUL};
    if (accept) begin
      int_result_q <= i_int_result;
    end
    if (o_div_start) begin
      div_op_q <= i_req.op;  // Kept for the special-case fix at the end
      div_a_q  <= i_req.a;
      div_b_q  <= i_req.b;
    end
  end

  assign mul_result = hi_pipe_q[`ALU_MUL_STAGES-1] ? i_product[63:32] : i_product[31:0];

  // RISC-V divide by zero and signed overflow results
  assign div_is_rem  = div_op_q inside {REM, REMU};
  assign div_by_zero = (div_b_q == '0);
  assign div_ovf     = (div_op_q inside {DIV, REM}) &&
                       (div_a_q == SIGNED_MIN) && (div_b_q == NEG_ONE);

  always_comb begin
    if (div_by_zero) begin
      if (div_is_rem) div_result = div_a_q;
      else            div_result = NEG_ONE;  // All ones for DIV and DIVU alike
    end else if (div_ovf) begin
      div_result = div_is_rem ? '0 : SIGNED_MIN;
    end else begin
      div_result = div_is_rem ? i_remainder : i_quotient;
    end
  end

  // Base results come from the local register, long ops from registered unit outputs
  assign o_rsp_valid = int_valid_q || i_mul_valid || i_div_done;

  always_comb begin
    o_rsp.result = int_result_q;
    if (i_mul_valid)     o_rsp.result = mul_result;
    else if (i_div_done) o_rsp.result = div_result;
  end

  assign o_busy = (mul_cnt_q != '0) || div_busy_q;

endmodule

`default_nettype wire

// ==== alu_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_top (
  input  logic              i_clk,
  input  logic              i_rst,
  input  logic              i_req_valid,
  input  alu_pkg::alu_req_t i_req,
  output logic              o_rsp_valid,
  output alu_pkg::alu_rsp_t o_rsp,
  output logic              o_busy
);

  import alu_pkg::*;

  word_t     int_result;  // Combinational base result
  logic      mul_in_valid;
  mul_opnd_t mul_a;
  mul_opnd_t mul_b;
  logic      mul_out_valid;
  dword_t    product;
  logic      div_start;
  logic      div_signed;
  word_t     dividend;
  word_t     divisor;
  logic      div_done;
  word_t     quotient;
  word_t     remainder;

  alu_int_unit u_int_unit (
    .i_op     (i_req.op),
    .i_a      (i_req.a),
    .i_b      (i_req.b),
    .o_result (int_result)
  );

  alu_multiplier u_multiplier (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_valid   (mul_in_valid),
    .i_a       (mul_a),
    .i_b       (mul_b),
    .o_valid   (mul_out_valid),
    .o_product (product)
  );

  alu_divider u_divider (
    .i_clk       (i_clk),
    .i_rst       (i_rst),
    .i_start     (div_start),
    .i_signed    (div_signed),
    .i_dividend  (dividend),
    .i_divisor   (divisor),
    .o_done      (div_done),
    .o_quotient  (quotient),
    .o_remainder (remainder)
  );

  alu_muldiv_seq u_seq (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .i_req_valid  (i_req_valid),
    .i_req        (i_req),
    .i_int_result (int_result),
    .i_product    (product),
    .i_mul_valid  (mul_out_valid),
    .i_div_done   (div_done),
    .i_quotient   (quotient),
    .i_remainder  (remainder),
    .o_mul_valid  (mul_in_valid),
    .o_mul_a      (mul_a),
    .o_mul_b      (mul_b),
    .o_div_start  (div_start),
    .o_div_signed (div_signed),
    .o_dividend   (dividend),
    .o_divisor    (divisor),
    .o_rsp_valid  (o_rsp_valid),
    .o_rsp        (o_rsp),
    .o_busy       (o_busy)
  );

endmodule

`default_nettype wire

// ==== tb_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_alu;

  import alu_pkg::*;

  localparam int RSP_LIMIT  = 100;  // Longest op is 33 cycles
  localparam int IDLE_LIMIT = 100;
  localparam int N_RANDOM   = 16;

  // One table row, its name sits at the same index in names
  typedef struct packed {
    alu_op_e op;
    word_t   a;
    word_t   b;
    word_t   exp;
    word_t   lat;  // Cycles from sampling edge to response
  } vec_t;

  logic     clk;
  logic     rst;
  logic     req_valid;
  alu_req_t req;
  logic     rsp_valid;
  alu_rsp_t rsp;
  logic     busy;

  vec_t  vecs[$];
  string names[$];
  int    errors;
  int    checks;
  bit    timed_out;  // Set once any wait gives up

  alu_top u_alu_top (
    .i_clk       (clk),
    .i_rst       (rst),
    .i_req_valid (req_valid),
    .i_req       (req),
    .o_rsp_valid (rsp_valid),
    .o_rsp       (rsp),
    .o_busy      (busy)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  task automatic check(input string name, input word_t exp, input word_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic note_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("Timeout: %s", what);
  endtask

  // Reference behavior straight from the RISC-V op definitions
  function automatic word_t model(input alu_op_e op, input word_t a, input word_t b);
    logic signed [31:0] sa;
    logic signed [31:0] sb;
    logic [63:0]        ea;
    logic [63:0]        eb;
    logic [63:0]        prod;
    logic [4:0]         sh;
    word_t              r;
    sa = a;
    sb = b;
    sh = b[4:0];
    ea = (op == MULH || op == MULHSU) ? {{32{a[31]}}, a} : {32'd0, a};
    eb = (op == MULH) ? {{32{b[31]}}, b} : {32'd0, b};
    prod = ea * eb;  // Modulo 2^64 is enough for both halves
    case (op)
      ADD:    r = a + b;
      SUB:    r = a - b;
      AND:    r = a & b;
      OR:     r = a | b;
      XOR:    r = a ^ b;
      SLL:    r = a << sh;
      SRL:    r = a >> sh;
      SRA:    r = sa >>> sh;
      SLT:    r = word_t'(sa < sb);
      SLTU:   r = word_t'(a < b);
      SH1ADD: r = (a << 1) + b;
      SH2ADD: r = (a << 2) + b;
      SH3ADD: r = (a << 3) + b;
      BSET:   r = a | (32'd1 << sh);
      BCLR:   r = a & ~(32'd1 << sh);
      BINV:   r = a ^ (32'd1 << sh);
      BEXT:   r = {31'd0, a[sh]};
      ANDN:   r = a & ~b;
      ORN:    r = a | ~b;
      XNOR:   r = ~(a ^ b);
      MIN:    r = (sa < sb) ? a : b;
      MINU:   r = (a < b) ? a : b;
      MAX:    r = (sa > sb) ? a : b;
      MAXU:   r = (a > b) ? a : b;
      ROL:    r = (a << sh) | (a >> (32 - int'(sh)));  // Shift by 32 gives zero
      ROR:    r = (a >> sh) | (a << (32 - int'(sh)));
      SEXT_B: r = 32'($signed(a[7:0]));
      SEXT_H: r = 32'($signed(a[15:0]));
      MUL:    r = prod[31:0];
      MULH, MULHSU, MULHU: r = prod[63:32];
      DIV: begin
        if (b == '0) r = '1;
        else if (a == 32'h8000_0000 && b == '1) r = a;  // Overflow keeps dividend
        else r = sa / sb;
      end
      DIVU:   r = (b == '0) ? '1 : a / b;
      REM: begin
        if (b == '0) r = a;
        else if (a == 32'h8000_0000 && b == '1) r = '0;
        else r = sa % sb;
      end
      REMU:   r = (b == '0) ? a : a % b;
      default: r = '0;
    endcase
    return r;
  endfunction

  function automatic int latency_of(input alu_op_e op);
    if (op inside {MUL, MULH, MULHSU, MULHU}) return 4;
    if (op inside {DIV, DIVU, REM, REMU}) return 33;  // Load plus 32 steps
    return 1;
  endfunction

  task automatic add_vec(input string name, input alu_op_e op, input word_t a,
                         input word_t b, input word_t exp);
    vec_t v;
    v.op  = op;
    v.a   = a;
    v.b   = b;
    v.exp = exp;
    v.lat = word_t'(latency_of(op));
    vecs.push_back(v);
    names.push_back(name);
  endtask

  // Fixed cases, expected values worked out by hand
  task automatic build_table();
    add_vec("add overflow", ADD, 32'h7FFF_FFFF, 32'h0000_0001, 32'h8000_0000);
    add_vec("sub wrap", SUB, 32'h0000_0000, 32'h0000_0001, 32'hFFFF_FFFF);
    add_vec("and", AND, 32'hF0F0_F0F0, 32'hFF00_FF00, 32'hF000_F000);
    add_vec("or", OR, 32'h1234_0000, 32'h0000_5678, 32'h1234_5678);
    add_vec("xor", XOR, 32'hFFFF_0000, 32'h0F0F_0F0F, 32'hF0F0_0F0F);
    add_vec("sll 31", SLL, 32'h0000_0001, 32'h0000_001F, 32'h8000_0000);
    add_vec("sll 0", SLL, 32'h1234_5678, 32'h0000_0000, 32'h1234_5678);
    add_vec("sll low bits", SLL, 32'h0000_0001, 32'h0000_0024, 32'h0000_0010);
    add_vec("srl 31", SRL, 32'h8000_0000, 32'h0000_001F, 32'h0000_0001);
    add_vec("sra 31", SRA, 32'h8000_0000, 32'h0000_001F, 32'hFFFF_FFFF);
    add_vec("sra 0", SRA, 32'h8000_0000, 32'h0000_0000, 32'h8000_0000);
    add_vec("slt neg", SLT, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001);
    add_vec("sltu neg", SLTU, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0000);
    add_vec("slt pos", SLT, 32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0000);
    add_vec("sltu pos", SLTU, 32'h0000_0001, 32'hFFFF_FFFF, 32'h0000_0001);
    add_vec("slt min max", SLT, 32'h8000_0000, 32'h7FFF_FFFF, 32'h0000_0001);
    add_vec("sh1add", SH1ADD, 32'h0000_0010, 32'h0000_0003, 32'h0000_0023);
    add_vec("sh2add", SH2ADD, 32'h0000_0010, 32'h0000_0003, 32'h0000_0043);
    add_vec("sh3add", SH3ADD, 32'h0000_0010, 32'h0000_0003, 32'h0000_0083);
    add_vec("bset", BSET, 32'h0000_0000, 32'h0000_001F, 32'h8000_0000);
    add_vec("bclr", BCLR, 32'hFFFF_FFFF, 32'h0000_0000, 32'hFFFF_FFFE);
    add_vec("binv", BINV, 32'h0000_00F0, 32'h0000_0004, 32'h0000_00E0);
    add_vec("bext set", BEXT, 32'h8000_0000, 32'h0000_001F, 32'h0000_0001);
    add_vec("bext clear", BEXT, 32'h8000_0000, 32'h0000_001E, 32'h0000_0000);
    add_vec("andn", ANDN, 32'hFFFF_FFFF, 32'h0000_FFFF, 32'hFFFF_0000);
    add_vec("orn", ORN, 32'h0000_0000, 32'hFFFF_0000, 32'h0000_FFFF);
    add_vec("xnor", XNOR, 32'hAAAA_AAAA, 32'h5555_5555, 32'h0000_0000);
    add_vec("min", MIN, 32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFFF);
    add_vec("minu", MINU, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001);
    add_vec("max", MAX, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0000_0001);
    add_vec("maxu", MAXU, 32'hFFFF_FFFF, 32'h0000_0001, 32'hFFFF_FFFF);
    add_vec("rol 1", ROL, 32'h8000_0001, 32'h0000_0001, 32'h0000_0003);
    add_vec("rol 0", ROL, 32'h1234_5678, 32'h0000_0000, 32'h1234_5678);
    add_vec("ror 1", ROR, 32'h8000_0001, 32'h0000_0001, 32'hC000_0000);
    add_vec("ror 0", ROR, 32'h1234_5678, 32'h0000_0000, 32'h1234_5678);
    add_vec("sext.b", SEXT_B, 32'h0000_0080, 32'h0000_0000, 32'hFFFF_FF80);
    add_vec("sext.h", SEXT_H, 32'h1234_7FFF, 32'h0000_0000, 32'h0000_7FFF);
    // Products, -1 and SIGNED_MIN corners
    add_vec("mul neg", MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001);
    add_vec("mulh neg", MULH, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0000);
    add_vec("mulhu ones", MULHU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE);
    add_vec("mulhsu ones", MULHSU, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF);
    add_vec("mulh min", MULH, 32'h8000_0000, 32'h8000_0000, 32'h4000_0000);
    add_vec("mulhsu min", MULHSU, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
    add_vec("mul small", MUL, 32'h0000_3039, 32'h0000_03E8, 32'h00BC_5EA8);
    // Quotient rounds toward zero, remainder follows dividend sign
    add_vec("div neg", DIV, 32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFD);
    add_vec("rem neg", REM, 32'hFFFF_FFF9, 32'h0000_0002, 32'hFFFF_FFFF);
    add_vec("div neg divisor", DIV, 32'h0000_0007, 32'hFFFF_FFFE, 32'hFFFF_FFFD);
    add_vec("rem neg divisor", REM, 32'h0000_0007, 32'hFFFF_FFFE, 32'h0000_0001);
    add_vec("divu", DIVU, 32'hFFFF_FFF9, 32'h0000_0002, 32'h7FFF_FFFC);
    add_vec("remu", REMU, 32'hFFFF_FFF9, 32'h0000_0002, 32'h0000_0001);
    add_vec("div by zero", DIV, 32'h0000_0064, 32'h0000_0000, 32'hFFFF_FFFF);
    add_vec("divu by zero", DIVU, 32'h0000_0064, 32'h0000_0000, 32'hFFFF_FFFF);
    add_vec("rem by zero", REM, 32'h0000_0064, 32'h0000_0000, 32'h0000_0064);
    add_vec("remu by zero", REMU, 32'h0000_0064, 32'h0000_0000, 32'h0000_0064);
    add_vec("div overflow", DIV, 32'h8000_0000, 32'hFFFF_FFFF, 32'h8000_0000);
    add_vec("rem overflow", REM, 32'h8000_0000, 32'hFFFF_FFFF, 32'h0000_0000);
  endtask

  task automatic wait_idle(input string name);
    int cyc;
    cyc = 0;
    @(negedge clk);
    while (busy && cyc < IDLE_LIMIT) begin
      @(negedge clk);
      cyc++;
    end
    if (busy) note_timeout({"DUT stayed busy before ", name});
  endtask

  // One-cycle strobe, inputs change 2 ns after the edge
  task automatic drive_req(input alu_req_t r);
    @(posedge clk);
    #2;
    req_valid = 1'b1;
    req       = r;
    @(posedge clk);
    #2;
    req_valid = 1'b0;
  endtask

  // Latency counts edges after the sampling edge, read at the falling edge
  task automatic wait_rsp(input string name, output int lat, output word_t res);
    lat = 1;
    @(negedge clk);
    while (!rsp_valid && lat < RSP_LIMIT) begin
      @(negedge clk);
      lat++;
    end
    res = rsp.result;
    if (!rsp_valid) note_timeout({"no response for ", name});
  endtask

  task automatic run_vec(input string name, input vec_t v);
    alu_req_t r;
    int       lat;
    word_t    res;
    r.op = v.op;
    r.a  = v.a;
    r.b  = v.b;
    wait_idle(name);
    if (timed_out) return;
    drive_req(r);
    wait_rsp(name, lat, res);
    if (timed_out) return;
    check({name, " result"}, v.exp, res);
    check({name, " latency"}, v.lat, word_t'(lat));
  endtask

  // Four products back to back, answers on four consecutive cycles
  task automatic stream_muls();
    alu_op_e ops[4];
    word_t   exps[4];
    ops  = '{MUL, MULH, MULHSU, MULHU};
    exps = '{32'hFFFF_FFFA, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0002};  // -2 times 3
    wait_idle("mul stream");
    if (timed_out) return;
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      #2;
      req_valid = 1'b1;
      req.op    = ops[i];
      req.a     = 32'hFFFF_FFFE;
      req.b     = 32'h0000_0003;
    end
    @(posedge clk);
    #2;
    req_valid = 1'b0;
    for (int i = 0; i < 4; i++) begin
      @(negedge clk);  // First one lands four cycles after its request
      check($sformatf("mul stream %0d valid", i), 32'd1, word_t'(rsp_valid));
      check($sformatf("mul stream %0d result", i), exps[i], rsp.result);
    end
    @(negedge clk);
    check("mul stream end", 32'd0, word_t'(rsp_valid));
  endtask

  task automatic drop_while_busy();
    alu_req_t r;
    int       lat;
    word_t    res;
    wait_idle("drop test");
    if (timed_out) return;
    r.op = DIV;
    r.a  = 32'd100;
    r.b  = 32'd7;
    drive_req(r);
    @(negedge clk);
    check("drop busy high", 32'd1, word_t'(busy));
    r.op = ADD;  // Arrives while the divide runs
    r.a  = 32'd1;
    r.b  = 32'd2;
    drive_req(r);
    wait_rsp("drop div", lat, res);
    if (timed_out) return;
    check("drop div result", 32'd14, res);
    check("drop div latency", 32'd33, word_t'(lat + 2));  // Two cycles spent on the ADD
    repeat (4) begin
      @(negedge clk);
      check("drop no extra response", 32'd0, word_t'(rsp_valid));
    end
    r.a = 32'd5;
    r.b = 32'd6;
    drive_req(r);
    wait_rsp("add after drop", lat, res);
    if (timed_out) return;
    check("add after drop result", 32'd11, res);
    check("add after drop latency", 32'd1, word_t'(lat));
  endtask

  initial begin
    int      seed_ret;
    alu_op_e rop;
    word_t   ra;
    word_t   rb;
    seed_ret  = $urandom(93);
    errors    = 0;
    checks    = 0;
    timed_out = 1'b0;
    rst       = 1'b1;
    req_valid = 1'b0;
    req       = '0;
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;

    repeat (5) begin
      @(negedge clk);
      check("reset rsp_valid", 32'd0, word_t'(rsp_valid));
      check("reset busy", 32'd0, word_t'(busy));
    end

    build_table();
    for (int i = 0; i < N_RANDOM; i++) begin
      rop = alu_op_e'(6'($urandom_range(35, 0)));
      ra  = $urandom();
      rb  = $urandom();
      add_vec($sformatf("random %0d %s", i, rop.name()), rop, ra, rb, model(rop, ra, rb));
    end

    foreach (vecs[i]) begin
      if (!timed_out) run_vec(names[i], vecs[i]);
    end
    if (!timed_out) stream_muls();
    if (!timed_out) drop_while_busy();

    repeat (8) begin
      @(negedge clk);
      check("idle rsp_valid", 32'd0, word_t'(rsp_valid));
    end

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+.
alu_pkg.sv
alu_int_unit.sv
alu_multiplier.sv
alu_divider.sv
alu_muldiv_seq.sv
alu_top.sv
tb_alu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the ALU testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_alu -f filelist.f \
  --Mdir obj_dir -o Vtb_alu
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_alu > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "test failed" "$LOG"; then
  exit 1
fi
exit 0
